/* risc5_pkg.sv */
// RISC5 system bus definitions
// request struct, I/O slot numbers and memory map constants
`default_nettype none

package risc5_pkg;

  // --------------------
  // memory map
  // --------------------

  // upper address bits that select the I/O window
  // (top 64 bytes of the 24-bit space)
  localparam logic [17:0] IO_BASE_HI = 18'h3FFFF;

  // ram word address width, 4096 words
  localparam int RAM_AW = 12;

  // --------------------
  // device constants
  // --------------------

  // clk cycles per millisecond at 25 MHz
  localparam int TICKS_PER_MS = 25000;

  // board I/O field widths
  localparam int LED_W = 8;
  localparam int SW_W = 8;
  localparam int BTN_W = 4;

  // --------------------
  // bus types
  // --------------------

  // one cpu request, valid for a single cycle
  typedef struct packed {
    // byte address
    logic [23:0] adr;
    // read strobe
    logic rd;
    // write strobe
    logic wr;
    // byte access, lane from adr[1:0]
    logic ben;
    // write data, byte writes use bits 7..0
    logic [31:0] wdata;
  } cpu_req_t;

  // I/O slot number, taken from adr[5:2]
  // slots 2..15 are free
  typedef enum logic [3:0] {
    IO_TMR = 4'd0,
    IO_BIO = 4'd1
  } io_slot_t;

endpackage

`default_nettype wire

/* ram.sv */
// word-organized RAM for the RISC5 bus
// byte-lane writes and zero-extended byte reads
`timescale 1ns/1ns
`default_nettype none

module ram (
  input  logic                clk,
  input  risc5_pkg::cpu_req_t req,
  input  logic                we,
  output logic [31:0]         rdata
);

  import risc5_pkg::*;

  // storage, 2**RAM_AW words
  logic [31:0] mem [2**RAM_AW];

  // word index and byte lane
  logic [RAM_AW-1:0] word_adr;
  logic [1:0] lane;

  // word at the current address
  logic [31:0] word;

  // selected byte of that word
  logic [7:0] byte_rd;

  // --------------------
  // address split
  // --------------------

  // upper address bits are dropped, so memory aliases
  assign word_adr = req.adr[RAM_AW+1:2];
  assign lane = req.adr[1:0];

  // --------------------
  // write port
  // --------------------

  // stored at the edge ending the strobe cycle
  always_ff @(posedge clk) begin
    if (we) begin
      if (req.ben) begin
        // only the addressed lane changes
        // data always comes from wdata[7:0]
        mem[word_adr][8*lane +: 8] <= req.wdata[7:0];
      end else begin
        mem[word_adr] <= req.wdata;
      end
    end
  end

  // --------------------
  // read port
  // --------------------

  // combinational, same cycle as rd
  assign word = mem[word_adr];

  // lane 0 is the least significant byte
  always_comb begin
    case (lane)
      2'd0: byte_rd = word[7:0];
      2'd1: byte_rd = word[15:8];
      2'd2: byte_rd = word[23:16];
      default: byte_rd = word[31:24];
    endcase
  end

  // byte reads are zero-extended
  always_comb begin
    if (req.ben) begin
      rdata = {24'h0, byte_rd};
    end else begin
      rdata = word;
    end
  end

endmodule

`default_nettype wire

/* tmr.sv */
// millisecond timer, I/O slot 0
// prescaler divides clk down to ms ticks, 32-bit tick count
`timescale 1ns/1ns
`default_nettype none

module tmr #(
  parameter int unsigned div = risc5_pkg::TICKS_PER_MS
) (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] rdata
);

  // prescaler, wide enough for any div
  logic [31:0] presc;

  // high in the last clk cycle of each ms
  logic ms_tick;

  // ms since reset
  logic [31:0] ms_cnt;

  // --------------------
  // prescaler
  // --------------------

  // counts 0 .. div-1 then starts over
  assign ms_tick = (presc == div - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      presc <= '0;
    end else if (ms_tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 32'd1;
    end
  end

  // --------------------
  // ms counter
  // --------------------

  // bumps at the edge after presc shows div-1,
  // so the new value is readable one cycle later
  // wraps at the top of its range
  always_ff @(posedge clk) begin
    if (reset) begin
      ms_cnt <= '0;
    end else if (ms_tick) begin
      ms_cnt <= ms_cnt + 32'd1;
    end
  end

  // --------------------
  // read data
  // --------------------

  // slot gating is done in the top level
  assign rdata = ms_cnt;

endmodule

`default_nettype wire

/* bio.sv */
// board I/O, I/O slot 1
// LED register plus synchronized switch and button inputs
`timescale 1ns/1ns
`default_nettype none

module bio (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        en,
  input  logic                        wr,
  input  logic [risc5_pkg::LED_W-1:0] wdata,
  output logic [31:0]                 rdata,
  output logic [risc5_pkg::LED_W-1:0] led,
  input  logic [risc5_pkg::SW_W-1:0]  sw,
  input  logic [risc5_pkg::BTN_W-1:0] btn
);

  import risc5_pkg::*;

  // synchronizer stages
  logic [SW_W-1:0] sw_s1;
  logic [SW_W-1:0] sw_s2;
  logic [BTN_W-1:0] btn_s1;
  logic [BTN_W-1:0] btn_s2;

  // --------------------
  // led register
  // --------------------

  // loads on a write to this slot
  // visible on the pins one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      led <= '0;
    end else if (en && wr) begin
      led <= wdata;
    end
  end

  // --------------------
  // input synchronizers
  // --------------------

  // two flops per pin, pins are asynchronous
  always_ff @(posedge clk) begin
    if (reset) begin
      sw_s1 <= '0;
      sw_s2 <= '0;
      btn_s1 <= '0;
      btn_s2 <= '0;
    end else begin
      sw_s1 <= sw;
      sw_s2 <= sw_s1;
      btn_s1 <= btn;
      btn_s2 <= btn_s1;
    end
  end

  // --------------------
  // read data
  // --------------------

  // switches in 11..4, buttons in 3..0
  assign rdata = {{(32 - SW_W - BTN_W){1'b0}}, sw_s2, btn_s2};

endmodule

`default_nettype wire

/* risc5_bus.sv */
// RISC5 system bus top level
// decodes the I/O window, steers write enables and muxes read data
`timescale 1ns/1ns
`default_nettype none

module risc5_bus #(
  parameter int unsigned tmr_div = risc5_pkg::TICKS_PER_MS
) (
  input  logic                       clk,
  input  logic                       reset,
  input  risc5_pkg::cpu_req_t        req,
  output logic [31:0]                rdata,
  output logic [risc5_pkg::LED_W-1:0] led,
  input  logic [risc5_pkg::SW_W-1:0]  sw,
  input  logic [risc5_pkg::BTN_W-1:0] btn
);

  import risc5_pkg::*;

  // decode results
  logic io_en;
  io_slot_t io_slot;
  logic tmr_en;
  logic bio_en;
  logic ram_we;

  // per target read data
  logic [31:0] ram_rdata;
  logic [31:0] tmr_rdata;
  logic [31:0] bio_rdata;

  // --------------------
  // address decoder
  // --------------------

  // I/O window is the top 64 bytes
  assign io_en = (req.adr[23:6] == IO_BASE_HI);

  // one word per slot
  assign io_slot = io_slot_t'(req.adr[5:2]);

  assign tmr_en = io_en && (io_slot == IO_TMR);
  assign bio_en = io_en && (io_slot == IO_BIO);

  // ram never sees writes aimed at the I/O window
  // addresses below it wrap modulo the ram size
  assign ram_we = req.wr && !io_en;

  // --------------------
  // devices
  // --------------------

  ram ram_1 (
    .clk   (clk),
    .req   (req),
    .we    (ram_we),
    .rdata (ram_rdata)
  );

  // slot 0, ms count
  tmr #(
    .div (tmr_div)
  ) tmr_1 (
    .clk   (clk),
    .reset (reset),
    .rdata (tmr_rdata)
  );

  // slot 1, leds, switches, buttons
  bio bio_1 (
    .clk   (clk),
    .reset (reset),
    .en    (bio_en),
    .wr    (req.wr),
    .wdata (req.wdata[LED_W-1:0]),
    .rdata (bio_rdata),
    .led   (led),
    .sw    (sw),
    .btn   (btn)
  );

  // --------------------
  // read data mux
  // --------------------

  // ram outside the window, else the selected device
  // unmapped slots read as zero
  always_comb begin
    if (!io_en) begin
      rdata = ram_rdata;
    end else if (tmr_en) begin
      rdata = tmr_rdata;
    end else if (bio_en) begin
      rdata = bio_rdata;
    end else begin
      rdata = 32'h0;
    end
  end

endmodule

`default_nettype wire

/* risc5_bus_checker.sv */
// bus and device assertions for the RISC5 system bus
// bound into every risc5_bus instance
`timescale 1ns/1ns
`default_nettype none

module risc5_bus_checker (
  input logic                        clk,
  input logic                        reset,
  input risc5_pkg::cpu_req_t         req,
  input logic [31:0]                 rdata,
  input logic [risc5_pkg::LED_W-1:0] led,
  input logic [31:0]                 tmr_cnt
);

  import risc5_pkg::*;

  // failed assertions, read by the testbench at the end
  int unsigned fails = 0;

  // own decode of the request
  logic in_io;
  logic [3:0] slot;

  assign in_io = (req.adr[23:6] == IO_BASE_HI);
  assign slot = req.adr[5:2];

  // --------------------
  // bus protocol
  // --------------------

  rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(req.rd && req.wr))
    else begin
      fails++;
      $error("rd and wr high in the same cycle");
    end

  // slots other than timer and board I/O read as zero
  unmapped_zero: assert property (@(posedge clk) disable iff (reset)
    (req.rd && in_io && slot != IO_TMR && slot != IO_BIO) |-> (rdata == 32'h0))
    else begin
      fails++;
      $error("unmapped I/O slot returned nonzero read data");
    end

  // --------------------
  // devices
  // --------------------

  // led follows a board I/O write one cycle later
  led_update: assert property (@(posedge clk) disable iff (reset)
    (req.wr && in_io && slot == IO_BIO) |=> (led == $past(req.wdata[LED_W-1:0])))
    else begin
      fails++;
      $error("led does not hold the value written to board I/O");
    end

  // ms count moves by at most one per cycle, wrap included
  tmr_step: assert property (@(posedge clk) disable iff (reset)
    ((tmr_cnt - $past(tmr_cnt)) <= 32'd1))
    else begin
      fails++;
      $error("timer count jumped by more than one");
    end

endmodule

bind risc5_bus risc5_bus_checker chk (
  .clk     (clk),
  .reset   (reset),
  .req     (req),
  .rdata   (rdata),
  .led     (led),
  .tmr_cnt (tmr_rdata)
);

`default_nettype wire

/* tb_risc5_bus.sv */
// testbench for the RISC5 system bus
// plays the CPU and checks RAM, board I/O, unmapped slots and the timer
`timescale 1ns/1ns
`default_nettype none

module tb_risc5_bus;

  import risc5_pkg::*;

  // run length guard, about 300 cycles are needed
  localparam int MAX_CYCLES = 2000;
  localparam int N_RAND = 40;

  logic clk = 1'b0;
  logic reset;
  cpu_req_t req;
  logic [31:0] rdata;
  logic [LED_W-1:0] led;
  logic [SW_W-1:0] sw;
  logic [BTN_W-1:0] btn;

  integer seed;
  int errors = 0;
  int cycles = 0;

  // reference copy of the RAM, indexed by word
  logic [31:0] model [2**RAM_AW];
  logic [23:0] adrs [N_RAND];

  risc5_bus #(
    .tmr_div (10)
  ) uut (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rdata (rdata),
    .led   (led),
    .sw    (sw),
    .btn   (btn)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------
  // helpers
  // --------------------

  function automatic cpu_req_t make_req(input logic [23:0] adr, input logic rd,
                                        input logic wr, input logic ben,
                                        input logic [31:0] wdata);
    cpu_req_t r;
    r.adr = adr;
    r.rd = rd;
    r.wr = wr;
    r.ben = ben;
    r.wdata = wdata;
    return r;
  endfunction

  // byte address of an I/O slot
  function automatic logic [23:0] io_adr(input logic [3:0] slot);
    return {IO_BASE_HI, slot, 2'b00};
  endfunction

  function automatic logic in_window(input logic [23:0] adr);
    return adr[23:6] == IO_BASE_HI;
  endfunction

  // memory wraps modulo its size
  function automatic logic [RAM_AW-1:0] word_of(input logic [23:0] adr);
    return adr[RAM_AW+1:2];
  endfunction

  // one request, returns mid-cycle where rdata has settled
  task automatic bus_cycle(input cpu_req_t r);
    @(posedge clk);
    req <= r;
    @(negedge clk);
  endtask

  task automatic bus_idle();
    bus_cycle(make_req(24'h0, 1'b0, 1'b0, 1'b0, 32'h0));
  endtask

  task automatic write_word(input logic [23:0] adr, input logic [31:0] data);
    bus_cycle(make_req(adr, 1'b0, 1'b1, 1'b0, data));
  endtask

  task automatic write_byte(input logic [23:0] adr, input logic [31:0] data);
    bus_cycle(make_req(adr, 1'b0, 1'b1, 1'b1, data));
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (got === exp)
      else begin
        errors++;
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
      end
  endtask

  task automatic read_check(input logic [23:0] adr, input logic ben,
                            input logic [31:0] exp);
    bus_cycle(make_req(adr, 1'b1, 1'b0, ben, 32'h0));
    compare_value("rdata", exp, rdata);
  endtask

  // --------------------
  // stimulus
  // --------------------

  initial begin
    logic [23:0] a;
    logic [31:0] d;
    logic [31:0] t0;
    logic [7:0] b;
    logic [SW_W-1:0] s;
    logic [BTN_W-1:0] bt;
    int unsigned total;
    seed = 91045;
    reset = 1'b1;
    req = make_req(24'h0, 1'b0, 1'b0, 1'b0, 32'h0);
    sw = '0;
    btn = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // random word writes, then read back, half of them through an alias
    for (int i = 0; i < N_RAND; i++) begin
      a = $random(seed);
      a[1:0] = 2'b00;
      if (in_window(a)) a[23] = 1'b0;
      d = $random(seed);
      adrs[i] = a;
      write_word(a, d);
      model[word_of(a)] = d;
    end
    for (int i = 0; i < N_RAND; i++) begin
      a = adrs[i];
      // flip the first address bit above the RAM
      if (i % 2 == 1) a = a ^ (24'h1 << (RAM_AW + 2));
      if (in_window(a)) a = adrs[i];
      read_check(a, 1'b0, model[word_of(a)]);
    end

    // byte lanes of one word
    a = 24'h000400;
    write_word(a, 32'hA5A5A5A5);
    model[word_of(a)] = 32'hA5A5A5A5;
    for (int lane = 0; lane < 4; lane++) begin
      b = $random(seed);
      // junk above bit 7 must not reach memory
      d = {$random(seed)};
      write_byte(a + 24'(lane), {d[31:8], b});
      model[word_of(a)][8*lane +: 8] = b;
      read_check(a, 1'b0, model[word_of(a)]);
      for (int k = 0; k < 4; k++) begin
        read_check(a + 24'(k), 1'b1, {24'h0, model[word_of(a)][8*k +: 8]});
      end
    end

    // board I/O leds
    for (int k = 0; k < 3; k++) begin
      d = $random(seed);
      write_word(io_adr(IO_BIO), d);
      bus_idle();
      compare_value("led", 32'(d[LED_W-1:0]), 32'(led));
    end

    // switches and buttons through the synchronizer
    for (int k = 0; k < 4; k++) begin
      s = $random(seed);
      bt = $random(seed);
      @(posedge clk);
      req <= make_req(24'h0, 1'b0, 1'b0, 1'b0, 32'h0);
      sw <= s;
      btn <= bt;
      bus_idle();
      read_check(io_adr(IO_BIO), 1'b0, {20'h0, s, bt});
    end

    // unmapped slots, with the RAM words they alias onto prefilled
    for (int k = 0; k < 16; k++) begin
      a = io_adr(4'(k));
      a[23:14] = '0;
      d = $random(seed);
      write_word(a, d);
      model[word_of(a)] = d;
    end
    for (int k = 2; k < 16; k++) begin
      read_check(io_adr(4'(k)), 1'b0, 32'h0);
      write_word(io_adr(4'(k)), $random(seed));
    end
    for (int k = 0; k < 16; k++) begin
      a = io_adr(4'(k));
      a[23:14] = '0;
      read_check(a, 1'b0, model[word_of(a)]);
    end

    // timer, restarted by a fresh reset
    @(posedge clk);
    req <= make_req(24'h0, 1'b0, 1'b0, 1'b0, 32'h0);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    read_check(io_adr(IO_TMR), 1'b0, 32'h0);
    bus_cycle(make_req(io_adr(IO_TMR), 1'b1, 1'b0, 1'b0, 32'h0));
    t0 = rdata;
    repeat (99) bus_idle();
    bus_cycle(make_req(io_adr(IO_TMR), 1'b1, 1'b0, 1'b0, 32'h0));
    // 100 cycles at div 10
    assert ((rdata - t0) == 32'd10 || (rdata - t0) == 32'd11)
      else begin
        errors++;
        $display("Fail at %0t: timer delta expected 10 or 11 got %0d", $time, rdata - t0);
      end
    bus_idle();

    total = errors + uut.chk.fails;
    $display("errors: %0d from testbench checks, %0d from assertions",
             errors, uut.chk.fails);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
risc5_pkg.sv
ram.sv
tmr.sv
bio.sv
risc5_bus.sv
risc5_bus_checker.sv
tb_risc5_bus.sv

/* Bender.yml */
package:
  name: risc5_bus

sources:
  # package first, then devices, then the top level
  - files:
      - risc5_pkg.sv
      - ram.sv
      - tmr.sv
      - bio.sv
      - risc5_bus.sv

  # verification sources
  - target: test
    files:
      - risc5_bus_checker.sv
      - tb_risc5_bus.sv
